// File: rtl/rob_pkg.sv
package rob_pkg;

  // datapath and buffer sizing
  localparam int xlen      = 32;
  localparam int rob_depth = 16;
  localparam int tag_w     = $clog2(rob_depth);
  localparam int reg_w     = 5;

  // rv32i major opcodes handled by the buffer
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    op_reg = 7'b0110011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111
  } opcode_e;

  // operation sent to the reservation station
  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    sll    = 4'd5,
    srl    = 4'd6,
    sra    = 4'd7,
    slt    = 4'd8,
    sltu   = 4'd9
  } alu_op_e;

  // life of one buffer slot
  typedef enum logic [1:0] {
    empty   = 2'd0,
    waiting = 2'd1,
    issued  = 2'd2,
    done    = 2'd3
  } entry_state_e;

endpackage

// File: rtl/rob_intake.sv
`timescale 1ns/10ps

module rob_intake import rob_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_req,
  input  logic [xlen-1:0] in_instr,
  input  logic [xlen-1:0] in_pc,
  input  logic            full,
  output logic            in_ack,
  output logic            enq,
  output logic [xlen-1:0] enq_instr,
  output logic [xlen-1:0] enq_pc
);

  typedef enum logic {
    hs_idle,
    hs_ack
  } hs_state_e;

  hs_state_e state_q;

  // one write per handshake, only while ack is still low
  assign enq       = in_req && (state_q == hs_idle) && !full;
  assign enq_instr = in_instr;
  assign enq_pc    = in_pc;
  assign in_ack    = (state_q == hs_ack);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= hs_idle;
    end else begin
      case (state_q)
        hs_idle: if (enq) state_q <= hs_ack;
        // hold ack until the source lets go of req
        hs_ack: if (!in_req) state_q <= hs_idle;
        default: state_q <= hs_idle;
      endcase
    end
  end

endmodule

// File: rtl/rob_entries.sv
`timescale 1ns/10ps

module rob_entries import rob_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             enq,
  input  logic [xlen-1:0]  enq_instr,
  input  logic [xlen-1:0]  enq_pc,
  input  logic             disp_we,
  input  logic [tag_w-1:0] disp_idx,
  input  entry_state_e     disp_state,
  input  logic [xlen-1:0]  disp_value,
  input  logic             disp_value_we,
  input  logic             cdb_valid,
  input  logic [tag_w-1:0] cdb_tag,
  input  logic [xlen-1:0]  cdb_value,
  input  logic             retire,
  input  logic [tag_w-1:0] rd_idx,
  output logic             full,
  output logic [tag_w-1:0] head,
  output logic [tag_w:0]   count,
  output logic [xlen-1:0]  rd_instr,
  output logic [xlen-1:0]  rd_pc,
  output entry_state_e     rd_state,
  output logic [xlen-1:0]  head_instr,
  output logic [xlen-1:0]  head_pc,
  output entry_state_e     head_state,
  output logic [xlen-1:0]  head_value
);

  logic [xlen-1:0] instr_mem [rob_depth];
  logic [xlen-1:0] pc_mem    [rob_depth];
  logic [xlen-1:0] value_mem [rob_depth];
  entry_state_e    state_q   [rob_depth];
  logic [tag_w-1:0] tail;

  // slot state and pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < rob_depth; i++) begin
        state_q[i] <= empty;
      end
    end else begin
      if (enq) begin
        state_q[tail] <= waiting;
        tail          <= tail + 1'b1;
      end
      if (disp_we) state_q[disp_idx] <= disp_state;
      // only issued slots ever see a cdb write
      if (cdb_valid) state_q[cdb_tag] <= done;
      if (retire) begin
        state_q[head] <= empty;
        head          <= head + 1'b1;
      end
      case ({enq, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // payload fields
  always_ff @(posedge clk) begin
    if (enq) begin
      instr_mem[tail] <= enq_instr;
      pc_mem[tail]    <= enq_pc;
    end
    if (disp_we && disp_value_we) value_mem[disp_idx] <= disp_value;
    if (cdb_valid) value_mem[cdb_tag] <= cdb_value;
  end

  assign full = (count == (tag_w + 1)'(rob_depth));

  // scan read port
  assign rd_instr = instr_mem[rd_idx];
  assign rd_pc    = pc_mem[rd_idx];
  assign rd_state = state_q[rd_idx];

  // head read port
  assign head_instr = instr_mem[head];
  assign head_pc    = pc_mem[head];
  assign head_state = state_q[head];
  assign head_value = value_mem[head];

endmodule

// File: rtl/alu_op_decode.sv
`timescale 1ns/10ps

module alu_op_decode import rob_pkg::*; (
  input  logic [xlen-1:0] instr,
  output alu_op_e         op,
  output logic [xlen-1:0] imm,
  output logic            use_imm
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       is_shift;

  assign opcode   = opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  // funct7 bit 30 picks sub and sra
  assign alt      = instr[30];
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  always_comb begin
    case (funct3)
      3'b000:  op = (opcode == op_reg && alt) ? sub : add;
      3'b001:  op = sll;
      3'b010:  op = slt;
      3'b011:  op = sltu;
      3'b100:  op = xor_op;
      3'b101:  op = alt ? sra : srl;
      3'b110:  op = or_op;
      default: op = and_op;
    endcase
  end

  always_comb begin
    use_imm = 1'b0;
    imm     = '0;
    if (opcode == op_imm) begin
      use_imm = 1'b1;
      if (is_shift) begin
        // shamt only
        imm = {{(xlen - 5){1'b0}}, instr[24:20]};
      end else begin
        imm = {{(xlen - 12){instr[31]}}, instr[31:20]};
      end
    end
  end

endmodule

// File: rtl/rob_dispatch.sv
`timescale 1ns/10ps

module rob_dispatch import rob_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             alu_ready,
  input  logic [tag_w-1:0] head,
  input  logic [tag_w:0]   count,
  input  logic [xlen-1:0]  rd_instr,
  input  logic [xlen-1:0]  rd_pc,
  input  entry_state_e     rd_state,
  output logic [tag_w-1:0] rd_idx,
  output logic             disp_we,
  output logic [tag_w-1:0] disp_idx,
  output entry_state_e     disp_state,
  output logic [xlen-1:0]  disp_value,
  output logic             disp_value_we,
  output logic             issue_valid,
  output logic [tag_w-1:0] issue_tag,
  output alu_op_e          issue_op,
  output logic [reg_w-1:0] issue_rs1,
  output logic [reg_w-1:0] issue_rs2,
  output logic [xlen-1:0]  issue_imm,
  output logic             issue_use_imm
);

  logic [tag_w-1:0] scan_ptr;
  logic [tag_w-1:0] scan_off;
  logic [tag_w:0]   count_q;
  logic             in_range;
  logic             is_waiting;
  logic             is_alu;
  logic             do_issue;
  logic             hold;
  opcode_e          opcode;
  alu_op_e          dec_op;
  logic [xlen-1:0]  dec_imm;
  logic             dec_use_imm;
  logic [xlen-1:0]  upper_imm;

  alu_op_decode u_decode (
    .instr   (rd_instr),
    .op      (dec_op),
    .imm     (dec_imm),
    .use_imm (dec_use_imm)
  );

  // new slots join the scan range a cycle after enqueue
  assign scan_off   = scan_ptr - head;
  assign in_range   = {1'b0, scan_off} < count_q;
  assign is_waiting = in_range && (rd_state == waiting);
  assign opcode     = opcode_e'(rd_instr[6:0]);
  assign is_alu     = (opcode == op_imm) || (opcode == op_reg);
  assign do_issue   = is_waiting && is_alu && alu_ready;
  assign hold       = is_waiting && is_alu && !alu_ready;
  assign upper_imm  = {rd_instr[31:12], 12'b0};
  assign rd_idx     = scan_ptr;
  assign disp_idx   = scan_ptr;

  always_comb begin
    disp_we       = is_waiting && (!is_alu || alu_ready);
    disp_value_we = is_waiting && !is_alu;
    if (is_alu) disp_state = issued;
    else disp_state = done;
    // immediate class finishes here
    case (opcode)
      lui:     disp_value = upper_imm;
      auipc:   disp_value = upper_imm + rd_pc;
      jal:     disp_value = rd_pc + xlen'(4);
      default: disp_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scan_ptr    <= '0;
      count_q     <= '0;
      issue_valid <= 1'b0;
    end else begin
      count_q     <= count;
      issue_valid <= do_issue;
      if (!in_range) scan_ptr <= head;
      else if (!hold) scan_ptr <= scan_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_issue) begin
      issue_tag     <= scan_ptr;
      issue_op      <= dec_op;
      issue_rs1     <= rd_instr[19:15];
      issue_rs2     <= rd_instr[24:20];
      issue_imm     <= dec_imm;
      issue_use_imm <= dec_use_imm;
    end
  end

endmodule

// File: rtl/rob_commit.sv
`timescale 1ns/10ps

module rob_commit import rob_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  entry_state_e     head_state,
  input  logic [xlen-1:0]  head_instr,
  input  logic [xlen-1:0]  head_value,
  input  logic [xlen-1:0]  head_pc,
  output logic             retire,
  output logic             commit_valid,
  output logic [reg_w-1:0] commit_rd,
  output logic [xlen-1:0]  commit_value,
  output logic [xlen-1:0]  commit_pc
);

  // only the head may leave, so order is kept
  assign retire = (head_state == done);

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= retire;
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      commit_rd    <= head_instr[7 +: reg_w];
      commit_value <= head_value;
      commit_pc    <= head_pc;
    end
  end

endmodule

// File: rtl/rob_top.sv
`timescale 1ns/10ps

module rob_top import rob_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_req,
  input  logic [xlen-1:0]  in_instr,
  input  logic [xlen-1:0]  in_pc,
  output logic             in_ack,
  input  logic             alu_ready,
  output logic             issue_valid,
  output logic [tag_w-1:0] issue_tag,
  output alu_op_e          issue_op,
  output logic [reg_w-1:0] issue_rs1,
  output logic [reg_w-1:0] issue_rs2,
  output logic [xlen-1:0]  issue_imm,
  output logic             issue_use_imm,
  input  logic             cdb_valid,
  input  logic [tag_w-1:0] cdb_tag,
  input  logic [xlen-1:0]  cdb_value,
  output logic             commit_valid,
  output logic [reg_w-1:0] commit_rd,
  output logic [xlen-1:0]  commit_value,
  output logic [xlen-1:0]  commit_pc
);

  // intake to entries
  logic             enq;
  logic [xlen-1:0]  enq_instr;
  logic [xlen-1:0]  enq_pc;
  logic             full;

  // dispatch side
  logic [tag_w-1:0] head;
  logic [tag_w:0]   count;
  logic [tag_w-1:0] rd_idx;
  logic [xlen-1:0]  rd_instr;
  logic [xlen-1:0]  rd_pc;
  entry_state_e     rd_state;
  logic             disp_we;
  logic [tag_w-1:0] disp_idx;
  entry_state_e     disp_state;
  logic [xlen-1:0]  disp_value;
  logic             disp_value_we;

  // commit side
  logic             retire;
  logic [xlen-1:0]  head_instr;
  logic [xlen-1:0]  head_pc;
  entry_state_e     head_state;
  logic [xlen-1:0]  head_value;

  rob_intake u_intake (
    .clk       (clk),
    .rst       (rst),
    .in_req    (in_req),
    .in_instr  (in_instr),
    .in_pc     (in_pc),
    .full      (full),
    .in_ack    (in_ack),
    .enq       (enq),
    .enq_instr (enq_instr),
    .enq_pc    (enq_pc)
  );

  rob_entries u_entries (
    .clk           (clk),
    .rst           (rst),
    .enq           (enq),
    .enq_instr     (enq_instr),
    .enq_pc        (enq_pc),
    .disp_we       (disp_we),
    .disp_idx      (disp_idx),
    .disp_state    (disp_state),
    .disp_value    (disp_value),
    .disp_value_we (disp_value_we),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .retire        (retire),
    .rd_idx        (rd_idx),
    .full          (full),
    .head          (head),
    .count         (count),
    .rd_instr      (rd_instr),
    .rd_pc         (rd_pc),
    .rd_state      (rd_state),
    .head_instr    (head_instr),
    .head_pc       (head_pc),
    .head_state    (head_state),
    .head_value    (head_value)
  );

  rob_dispatch u_dispatch (
    .clk           (clk),
    .rst           (rst),
    .alu_ready     (alu_ready),
    .head          (head),
    .count         (count),
    .rd_instr      (rd_instr),
    .rd_pc         (rd_pc),
    .rd_state      (rd_state),
    .rd_idx        (rd_idx),
    .disp_we       (disp_we),
    .disp_idx      (disp_idx),
    .disp_state    (disp_state),
    .disp_value    (disp_value),
    .disp_value_we (disp_value_we),
    .issue_valid   (issue_valid),
    .issue_tag     (issue_tag),
    .issue_op      (issue_op),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm)
  );

  rob_commit u_commit (
    .clk          (clk),
    .rst          (rst),
    .head_state   (head_state),
    .head_instr   (head_instr),
    .head_value   (head_value),
    .head_pc      (head_pc),
    .retire       (retire),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_value (commit_value),
    .commit_pc    (commit_pc)
  );

endmodule

// File: tb/rob_sva.sv
`timescale 1ns/10ps

module rob_sva import rob_pkg::*; (
  input logic             clk,
  input logic             rst,
  input logic             in_req,
  input logic             in_ack,
  input logic             alu_ready,
  input logic             issue_valid,
  input logic [tag_w-1:0] issue_tag,
  input logic             commit_valid,
  input logic [xlen-1:0]  commit_pc
);

  // ack only answers a request
  ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
    !in_req && !in_ack |=> !in_ack)
    else $error("in_ack rose while in_req was low");

  ack_holds_with_req: assert property (@(posedge clk) disable iff (rst)
    in_req && in_ack |=> in_ack)
    else $error("in_ack fell while in_req was high");

  issue_after_ready: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> $past(alu_ready))
    else $error("issue_valid without alu_ready in the cycle before");

  issue_single_pulse: assert property (@(posedge clk) disable iff (rst)
    issue_valid |=> !issue_valid || (issue_tag != $past(issue_tag)))
    else $error("issue_valid held two cycles for one tag");

  // back-to-back commits belong to different entries
  commit_single_pulse: assert property (@(posedge clk) disable iff (rst)
    commit_valid |=> !commit_valid || (commit_pc != $past(commit_pc)))
    else $error("commit repeated for one entry");

endmodule

bind rob_top rob_sva sva (
  .clk          (clk),
  .rst          (rst),
  .in_req       (in_req),
  .in_ack       (in_ack),
  .alu_ready    (alu_ready),
  .issue_valid  (issue_valid),
  .issue_tag    (issue_tag),
  .commit_valid (commit_valid),
  .commit_pc    (commit_pc)
);

// File: tb/rob_checker.sv
`timescale 1ns/10ps

module rob_checker import rob_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_ack,
  input  logic [xlen-1:0]  in_instr,
  input  logic [xlen-1:0]  in_pc,
  input  logic             issue_valid,
  input  logic [tag_w-1:0] issue_tag,
  input  alu_op_e          issue_op,
  input  logic [reg_w-1:0] issue_rs1,
  input  logic [reg_w-1:0] issue_rs2,
  input  logic [xlen-1:0]  issue_imm,
  input  logic             issue_use_imm,
  input  logic             cdb_valid,
  input  logic [tag_w-1:0] cdb_tag,
  input  logic [xlen-1:0]  cdb_value,
  input  logic             commit_valid,
  input  logic [reg_w-1:0] commit_rd,
  input  logic [xlen-1:0]  commit_value,
  input  logic [xlen-1:0]  commit_pc,
  output int               errors,
  output int               checks,
  output int               commits,
  output int               outstanding
);

  // program order of accepted instructions
  logic [xlen-1:0]  q_instr [$];
  logic [xlen-1:0]  q_pc [$];
  logic [tag_w-1:0] q_tag [$];
  logic [xlen-1:0]  cdb_val [rob_depth];
  logic             cdb_seen [rob_depth];
  logic             was_issued [rob_depth];
  logic [tag_w-1:0] next_tag;
  logic             ack_q;

  function automatic logic is_alu(input logic [xlen-1:0] w);
    return (w[6:0] == op_imm) || (w[6:0] == op_reg);
  endfunction

  // funct3 gives the op, funct7 of 0x20 picks sub and sra
  function automatic alu_op_e ref_op(input logic [xlen-1:0] w);
    logic alt;
    alt = (w[31:25] == 7'b0100000);
    case (w[14:12])
      3'b000:  return (alt && w[6:0] == op_reg) ? sub : add;
      3'b001:  return sll;
      3'b010:  return slt;
      3'b011:  return sltu;
      3'b100:  return xor_op;
      3'b101:  return alt ? sra : srl;
      3'b110:  return or_op;
      default: return and_op;
    endcase
  endfunction

  function automatic logic [xlen-1:0] ref_imm(input logic [xlen-1:0] w);
    // shifts carry only shamt
    if (w[13:12] == 2'b01) return {27'b0, w[24:20]};
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic int find_slot(input logic [tag_w-1:0] t);
    foreach (q_tag[i]) begin
      if (q_tag[i] == t) return i;
    end
    return -1;
  endfunction

  task automatic check_field(input string name, input logic [xlen-1:0] exp,
                             input logic [xlen-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("ERROR t=%0t: %s", $time, msg);
  endtask

  task automatic check_issue();
    int              idx;
    logic [xlen-1:0] w;
    idx = find_slot(issue_tag);
    if (idx < 0) begin
      report_fault($sformatf("issue for tag %0d with nothing in flight", issue_tag));
      return;
    end
    w = q_instr[idx];
    if (!is_alu(w)) begin
      report_fault($sformatf("non-ALU instruction at pc %h was issued", q_pc[idx]));
      return;
    end
    if (was_issued[issue_tag]) report_fault($sformatf("tag %0d issued twice", issue_tag));
    was_issued[issue_tag] = 1'b1;
    check_field("issue_op", 32'(ref_op(w)), 32'(issue_op));
    check_field("issue_use_imm", 32'(w[6:0] == op_imm), 32'(issue_use_imm));
    if (w[6:0] == op_imm) check_field("issue_imm", ref_imm(w), issue_imm);
    check_field("issue_rs1", 32'(w[19:15]), 32'(issue_rs1));
    check_field("issue_rs2", 32'(w[24:20]), 32'(issue_rs2));
  endtask

  task automatic check_commit();
    logic [xlen-1:0]  w;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  exp_val;
    logic [tag_w-1:0] t;
    if (q_instr.size() == 0) begin
      report_fault("commit with no instruction in flight");
      return;
    end
    w  = q_instr.pop_front();
    pc = q_pc.pop_front();
    t  = q_tag.pop_front();
    case (w[6:0])
      lui:     exp_val = {w[31:12], 12'b0};
      auipc:   exp_val = {w[31:12], 12'b0} + pc;
      jal:     exp_val = pc + 32'd4;
      default: begin
        if (!was_issued[t]) report_fault($sformatf("pc %h committed without issue", pc));
        if (!cdb_seen[t]) report_fault($sformatf("pc %h committed without a result", pc));
        exp_val = cdb_val[t];
      end
    endcase
    check_field("commit_rd", 32'(w[11:7]), 32'(commit_rd));
    check_field("commit_pc", pc, commit_pc);
    check_field("commit_value", exp_val, commit_value);
    commits++;
  endtask

  // sampled mid-cycle, away from both driving edges
  always @(negedge clk) begin
    if (rst) begin
      q_instr.delete();
      q_pc.delete();
      q_tag.delete();
      for (int i = 0; i < rob_depth; i++) begin
        cdb_seen[i]   = 1'b0;
        was_issued[i] = 1'b0;
      end
      next_tag    = '0;
      ack_q       = 1'b0;
      errors      = 0;
      checks      = 0;
      commits     = 0;
      outstanding = 0;
    end else begin
      if (in_ack && !ack_q) begin
        q_instr.push_back(in_instr);
        q_pc.push_back(in_pc);
        q_tag.push_back(next_tag);
        cdb_seen[next_tag]   = 1'b0;
        was_issued[next_tag] = 1'b0;
        next_tag             = next_tag + 1'b1;
      end
      ack_q = in_ack;
      if (cdb_valid) begin
        if (!was_issued[cdb_tag]) begin
          report_fault($sformatf("cdb write to tag %0d that was not issued", cdb_tag));
        end
        cdb_val[cdb_tag]  = cdb_value;
        cdb_seen[cdb_tag] = 1'b1;
      end
      if (issue_valid) check_issue();
      if (commit_valid) check_commit();
      outstanding = q_instr.size();
    end
  end

endmodule

// File: tb/rob_tb.sv
`timescale 1ns/10ps

module rob_tb import rob_pkg::*; ();

  localparam int seed        = 32'h515d;
  localparam int num_random  = 300;
  localparam int num_upper   = 20;
  localparam int ack_limit   = 400;
  localparam int drain_limit = 2000;
  localparam int full_watch  = 30;

  logic             clk;
  logic             rst;
  logic             in_req;
  logic [xlen-1:0]  in_instr;
  logic [xlen-1:0]  in_pc;
  logic             in_ack;
  logic             alu_ready;
  logic             issue_valid;
  logic [tag_w-1:0] issue_tag;
  alu_op_e          issue_op;
  logic [reg_w-1:0] issue_rs1;
  logic [reg_w-1:0] issue_rs2;
  logic [xlen-1:0]  issue_imm;
  logic             issue_use_imm;
  logic             cdb_valid;
  logic [tag_w-1:0] cdb_tag;
  logic [xlen-1:0]  cdb_value;
  logic             commit_valid;
  logic [reg_w-1:0] commit_rd;
  logic [xlen-1:0]  commit_value;
  logic [xlen-1:0]  commit_pc;

  logic hold_ready;
  int   tb_errors;
  int   tb_checks;
  int   err_mark;
  int   test_count;
  int   chk_errors;
  int   chk_checks;
  int   chk_commits;
  int   chk_outstanding;

  rob_top dut (.*);

  rob_checker chk (
    .errors      (chk_errors),
    .checks      (chk_checks),
    .commits     (chk_commits),
    .outstanding (chk_outstanding),
    .*
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reservation station stand-in, results come back out of order
  initial begin : alu_responder
    logic [tag_w-1:0] pending [$];
    int               pick;
    alu_ready = 1'b0;
    cdb_valid = 1'b0;
    cdb_tag   = '0;
    cdb_value = '0;
    forever begin
      @(posedge clk);
      #1;
      cdb_valid = 1'b0;
      alu_ready = !hold_ready && ($urandom_range(3) != 0);
      if (pending.size() > 0 && $urandom_range(2) == 0) begin
        pick      = $urandom_range(pending.size() - 1);
        cdb_tag   = pending[pick];
        cdb_value = $urandom;
        cdb_valid = 1'b1;
        pending.delete(pick);
      end
      if (issue_valid) pending.push_back(issue_tag);
    end
  end

  function automatic opcode_e pick_kind(input logic alu_allowed);
    int r;
    if (alu_allowed) r = $urandom_range(7);
    else r = 5 + $urandom_range(2);
    case (r)
      0, 1, 2: return op_imm;
      3, 4:    return op_reg;
      5:       return lui;
      6:       return auipc;
      default: return jal;
    endcase
  endfunction

  // random fields, funct7 kept legal where it selects sub or sra
  function automatic logic [31:0] gen_instr(input opcode_e kind);
    logic [31:0] w;
    logic        alt;
    w   = $urandom;
    alt = w[30];
    if (kind == op_reg || (kind == op_imm && w[13:12] == 2'b01)) begin
      w[31:25] = 7'b0;
      if (w[14:12] == 3'b101 || (kind == op_reg && w[14:12] == 3'b000)) w[30] = alt;
    end
    w[6:0] = kind;
    return w;
  endfunction

  function automatic logic [31:0] gen_pc();
    return $urandom & 32'hffff_fffc;
  endfunction

  task automatic timeout_fail(input string what);
    $display("timeout at t=%0t: %s", $time, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic expect_bit(input string name, input logic exp, input logic got);
    tb_checks++;
    if (got !== exp) begin
      tb_errors++;
      $display("ERROR t=%0t %s exp=%b got=%b", $time, name, exp, got);
    end
  endtask

  task automatic finish_test(input string name);
    int n;
    n = tb_errors + chk_errors - err_mark;
    test_count++;
    if (n == 0) $display("test %0d %s: ok", test_count, name);
    else $display("test %0d %s: %0d errors", test_count, name, n);
    err_mark = tb_errors + chk_errors;
  endtask

  task automatic raise_req(input logic [31:0] instr, input logic [31:0] pc);
    @(posedge clk);
    #1;
    in_instr = instr;
    in_pc    = pc;
    in_req   = 1'b1;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    while (!in_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > ack_limit) timeout_fail("in_ack did not rise after in_req");
    end
  endtask

  task automatic drop_req();
    int n;
    in_req = 1'b0;
    n = 0;
    while (in_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > ack_limit) timeout_fail("in_ack did not fall after in_req dropped");
    end
  endtask

  // one full four-phase handshake
  task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc);
    raise_req(instr, pc);
    wait_ack();
    drop_req();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (chk_outstanding != 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > drain_limit) timeout_fail("buffer did not drain");
    end
  endtask

  initial begin : main
    int seed_state;
    int commit_mark;
    tb_errors  = 0;
    tb_checks  = 0;
    err_mark   = 0;
    test_count = 0;
    hold_ready = 1'b0;
    rst        = 1'b1;
    in_req     = 1'b0;
    in_instr   = '0;
    in_pc      = '0;
    seed_state = $urandom(seed);

    repeat (16) @(posedge clk);
    #1;
    expect_bit("in_ack", 1'b0, in_ack);
    expect_bit("issue_valid", 1'b0, issue_valid);
    expect_bit("commit_valid", 1'b0, commit_valid);
    rst = 1'b0;
    // nothing accepted yet, so no commit may show up
    repeat (8) begin
      @(posedge clk);
      #1;
      expect_bit("commit_valid", 1'b0, commit_valid);
    end
    finish_test("reset_values");

    for (int i = 0; i < num_random; i++) begin
      send_instr(gen_instr(pick_kind(1'b1)), gen_pc());
    end
    wait_drain();
    finish_test("random_mix");

    // upper-immediate class must finish with the alu stalled
    hold_ready = 1'b1;
    for (int i = 0; i < num_upper; i++) begin
      send_instr(gen_instr(pick_kind(1'b0)), gen_pc());
    end
    wait_drain();
    hold_ready = 1'b0;
    finish_test("upper_imm_jal");

    hold_ready = 1'b1;
    for (int i = 0; i < rob_depth; i++) begin
      send_instr(gen_instr(i[0] ? op_reg : op_imm), gen_pc());
    end
    raise_req(gen_instr(op_reg), gen_pc());
    for (int i = 0; i < full_watch; i++) begin
      @(posedge clk);
      #1;
      expect_bit("in_ack", 1'b0, in_ack);
    end
    commit_mark = chk_commits;
    hold_ready  = 1'b0;
    wait_ack();
    tb_checks++;
    if (chk_commits <= commit_mark) begin
      tb_errors++;
      $display("ERROR t=%0t: request accepted before a commit freed a slot", $time);
    end
    drop_req();
    wait_drain();
    finish_test("full_buffer");

    $display("tests: %0d, checks: %0d, errors: %0d", test_count,
             tb_checks + chk_checks, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: rob_top.f
rtl/rob_pkg.sv
rtl/rob_intake.sv
rtl/rob_entries.sv
rtl/alu_op_decode.sv
rtl/rob_dispatch.sv
rtl/rob_commit.sv
rtl/rob_top.sv
tb/rob_sva.sv
tb/rob_checker.sv
tb/rob_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the reorder buffer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rob_top.f --top-module rob_tb \
  --Mdir obj_dir -o rob_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
